//--- compile.f
+incdir+verilog
+incdir+tests
verilog/core_pkg.sv
verilog/issue_if.sv
verilog/result_if.sv
verilog/register_file.sv
verilog/decode_issue.sv
verilog/execute_units.sv
verilog/writeback.sv
verilog/int_core_top.sv
tests/tb_int_core.sv

//--- tests/tb_core_model.svh
/* Reference model of the core, included inside the testbench module.
   Relies on core_pkg being imported there */

`ifndef TB_CORE_MODEL_SVH
`define TB_CORE_MODEL_SVH

localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_LUI    = 7'b0110111;

// Edges from acceptance to the visible write-back
localparam int ALU_WB_DELAY = 2;
localparam int MUL_WB_DELAY = 4;

int          error_count = 0;
int          outstanding = 0;
logic [15:0] lfsr_state  = 16'd74;

// Architectural state and per-register expected results
word_t model_regs [32];
word_t exp_val [32][$];
int    exp_cyc [32][$];
int    ill_cyc [$];

//////////////////////////////////////////////////
// Random source
//////////////////////////////////////////////////

// Taps 16, 14, 13, 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

//////////////////////////////////////////////////
// Instruction encoders
//////////////////////////////////////////////////

function automatic instr_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3,
                                  input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic instr_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                  input logic [2:0] f3, input reg_addr_t rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
endfunction

function automatic instr_t lui_word(input logic [19:0] imm, input reg_addr_t rd);
    return {imm, rd, OPC_LUI};
endfunction

//////////////////////////////////////////////////
// ISA rules
//////////////////////////////////////////////////

function automatic logic is_supported(input instr_t ins);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = ins[14:12];
    f7 = ins[31:25];
    case (ins[6:0])
        OPC_OP: begin
            return (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5))
                || ((f7 == 7'h01) && (f3 == 3'd0));
        end
        OPC_OP_IMM: begin
            if (f3 == 3'd1) begin
                return f7 == 7'h00;
            end
            if (f3 == 3'd5) begin
                return (f7 == 7'h00) || (f7 == 7'h20);
            end
            return 1'b1;
        end
        OPC_LUI: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic word_t golden_result(input instr_t ins, input word_t a, input word_t rs2_val);
    word_t      b;
    logic [2:0] f3;
    logic       is_op;
    f3    = ins[14:12];
    is_op = (ins[6:0] == OPC_OP);
    if (ins[6:0] == OPC_LUI) begin
        return {ins[31:12], 12'h000};
    end
    b = is_op ? rs2_val : {{20{ins[31]}}, ins[31:20]};
    if (is_op && ins[31:25] == 7'h01) begin
        return a * b;
    end
    case (f3)
        3'd0: return (is_op && ins[30]) ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: return (a < b) ? 32'd1 : 32'd0;
        3'd4: return a ^ b;
        3'd5: return ins[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

// Called in the cycle before the accepting edge
task automatic record_accept(input instr_t ins, input logic exp_illegal, input int edge_no);
    reg_addr_t rd;
    word_t     value;
    logic      legal;
    logic      is_mul;
    rd     = ins[11:7];
    legal  = is_supported(ins);
    is_mul = (ins[6:0] == OPC_OP) && (ins[31:25] == 7'h01);
    if (legal == exp_illegal) begin
        error_count++;
        $display("Stimulus table and model disagree on the legality of %h", ins);
    end
    if (!legal) begin
        ill_cyc.push_back(edge_no + 1);
        outstanding++;
    end else if (rd != '0) begin
        value = golden_result(ins, model_regs[ins[19:15]], model_regs[ins[24:20]]);
        model_regs[rd] = value;
        exp_val[rd].push_back(value);
        exp_cyc[rd].push_back(edge_no + (is_mul ? MUL_WB_DELAY : ALU_WB_DELAY));
        outstanding++;
    end
endtask

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        error_count++;
        $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic compare_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
        error_count++;
        $display("FAILED at %0t: %s is x%0d, expected x%0d", $time, name, got, exp);
    end
endtask

task automatic expect_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        error_count++;
        $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
endtask

`endif

//--- tests/tb_int_core.sv
/* Self-checking testbench for int_core_top. Write-backs are matched by
   register and by the exact edge the fixed unit latencies give */

`timescale 1ns/1ps
`default_nettype none

module tb_int_core
    import core_pkg::*;
();

    localparam int RESET_CYCLES = 2;
    localparam int RANDOM_COUNT = 40;
    localparam int GROUP_COUNT  = 6;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      instr_valid;
    instr_t    instr;
    logic      instr_ready;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;
    logic      illegal;

    int cycle         = 0;
    int timeout_limit = 50;
    int tests_run     = 0;
    int tests_passed  = 0;

    // Stimulus table with the expected illegal flag per row
    instr_t tbl_instr [$];
    int     tbl_group [$];
    logic   tbl_illegal [$];
    string  group_name [GROUP_COUNT];

    `include "tb_core_model.svh"

    int_core_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .illegal     (illegal)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_limit) begin
            $display("Timeout after %0d cycles, the core stopped making progress", cycle);
            $display("Verification failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    task automatic add_row(input int group, input instr_t ins, input logic ill);
        tbl_group.push_back(group);
        tbl_instr.push_back(ins);
        tbl_illegal.push_back(ill);
    endtask

    function automatic instr_t random_instr();
        logic [2:0]  kind;
        logic [2:0]  f3;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [11:0] imm;
        logic [6:0]  f7;
        logic [19:0] upper;
        // Registers x1..x8 only, all written by the directed part
        kind = rand_bits(3);
        rd   = rand_bits(3) + 1;
        rs1  = rand_bits(3) + 1;
        rs2  = rand_bits(3) + 1;
        f3   = rand_bits(3);
        case (kind)
            3'd0, 3'd1, 3'd2: begin
                f7 = ((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1)) ? 7'h20 : 7'h00;
                return r_type(f7, rs2, rs1, f3, rd);
            end
            3'd3, 3'd4: begin
                imm = rand_bits(12);
                if (f3 == 3'd1) begin
                    imm[11:5] = 7'h00;
                end else if (f3 == 3'd5) begin
                    imm[11:5] = rand_bits(1) ? 7'h20 : 7'h00;
                end
                return i_type(imm, rs1, f3, rd);
            end
            3'd5: return r_type(7'h01, rs2, rs1, 3'd0, rd);
            default: begin
                upper = rand_bits(20);
                return lui_word(upper, rd);
            end
        endcase
    endfunction

    task automatic build_table();
        instr_t ins;
        group_name = '{"imm_lui", "reg_alu", "mul_dep", "x0", "illegal", "random"};
        // Immediates, LUI and the register setup for later groups
        add_row(0, lui_word(20'h12345, 1), 1'b0);
        add_row(0, i_type(12'h678, 1, 3'd0, 1), 1'b0);
        add_row(0, i_type(12'hfff, 0, 3'd0, 2), 1'b0);
        add_row(0, lui_word(20'h80000, 3), 1'b0);
        add_row(0, i_type(12'h800, 0, 3'd0, 4), 1'b0);
        add_row(0, i_type(12'h007, 0, 3'd0, 5), 1'b0);
        add_row(0, i_type(12'hffb, 4, 3'd2, 6), 1'b0);
        add_row(0, i_type(12'hfff, 5, 3'd3, 7), 1'b0);
        add_row(0, i_type(12'hfff, 1, 3'd4, 8), 1'b0);
        add_row(0, i_type(12'h0f0, 5, 3'd6, 9), 1'b0);
        add_row(0, i_type(12'h7ff, 2, 3'd7, 10), 1'b0);
        add_row(0, i_type(12'h01c, 5, 3'd1, 11), 1'b0);
        add_row(0, i_type(12'h004, 3, 3'd5, 12), 1'b0);
        add_row(0, i_type(12'h404, 3, 3'd5, 13), 1'b0);
        // All ten register operations
        add_row(1, r_type(7'h00, 2, 1, 3'd0, 14), 1'b0);
        add_row(1, r_type(7'h20, 1, 5, 3'd0, 15), 1'b0);
        add_row(1, r_type(7'h00, 5, 1, 3'd1, 16), 1'b0);
        add_row(1, r_type(7'h00, 5, 3, 3'd2, 17), 1'b0);
        add_row(1, r_type(7'h00, 5, 3, 3'd3, 18), 1'b0);
        add_row(1, r_type(7'h00, 2, 1, 3'd4, 19), 1'b0);
        add_row(1, r_type(7'h00, 5, 3, 3'd5, 20), 1'b0);
        add_row(1, r_type(7'h20, 5, 3, 3'd5, 21), 1'b0);
        add_row(1, r_type(7'h00, 4, 1, 3'd6, 22), 1'b0);
        add_row(1, r_type(7'h00, 8, 1, 3'd7, 23), 1'b0);
        add_row(1, r_type(7'h20, 1, 2, 3'd5, 24), 1'b0);
        // Dependent chains and ALU ops right behind a MUL
        add_row(2, r_type(7'h01, 2, 1, 3'd0, 25), 1'b0);
        add_row(2, r_type(7'h01, 3, 3, 3'd0, 26), 1'b0);
        add_row(2, r_type(7'h01, 1, 1, 3'd0, 27), 1'b0);
        add_row(2, r_type(7'h00, 27, 25, 3'd0, 28), 1'b0);
        add_row(2, r_type(7'h01, 4, 28, 3'd0, 29), 1'b0);
        add_row(2, r_type(7'h20, 1, 29, 3'd0, 30), 1'b0);
        add_row(2, r_type(7'h01, 30, 30, 3'd0, 30), 1'b0);
        add_row(2, i_type(12'h001, 30, 3'd0, 31), 1'b0);
        add_row(2, r_type(7'h01, 5, 31, 3'd0, 25), 1'b0);
        add_row(2, r_type(7'h00, 5, 5, 3'd0, 26), 1'b0);
        add_row(2, r_type(7'h01, 6, 5, 3'd0, 27), 1'b0);
        add_row(2, i_type(12'h003, 5, 3'd0, 28), 1'b0);
        add_row(2, i_type(12'h004, 5, 3'd0, 29), 1'b0);
        // x0 as destination and as source
        add_row(3, i_type(12'h009, 5, 3'd0, 0), 1'b0);
        add_row(3, r_type(7'h00, 1, 1, 3'd0, 0), 1'b0);
        add_row(3, r_type(7'h01, 2, 1, 3'd0, 0), 1'b0);
        add_row(3, lui_word(20'hfffff, 0), 1'b0);
        add_row(3, r_type(7'h00, 5, 0, 3'd0, 14), 1'b0);
        add_row(3, r_type(7'h00, 0, 0, 3'd6, 15), 1'b0);
        add_row(3, r_type(7'h01, 0, 1, 3'd0, 17), 1'b0);
        // Load, divide, bad funct7 on sll and slli, all-zero word
        add_row(4, 32'h0000_2083, 1'b1);
        add_row(4, r_type(7'h01, 2, 1, 3'd4, 16), 1'b1);
        add_row(4, r_type(7'h20, 2, 1, 3'd1, 17), 1'b1);
        add_row(4, i_type(12'h405, 1, 3'd1, 18), 1'b1);
        add_row(4, 32'h0000_0000, 1'b1);
        add_row(4, i_type(12'h001, 0, 3'd0, 16), 1'b0);
        // The generator only builds supported encodings
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            ins = random_instr();
            add_row(5, ins, 1'b0);
        end
    endtask

    //////////////////////////////////////////////////
    // Drive and monitor
    //////////////////////////////////////////////////

    // Presents one row and holds it until the core accepts it
    task automatic drive_one(input int idx);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = tbl_instr[idx];
        #1;
        while (!instr_ready) begin
            @(negedge clk);
            #1;
        end
        record_accept(tbl_instr[idx], tbl_illegal[idx], cycle + 1);
        @(posedge clk);
    endtask

    task automatic report_test(input string name, input int errors);
        tests_run++;
        if (errors == 0) begin
            tests_passed++;
            $display("Test %-9s done: pass", name);
        end else begin
            $display("Test %-9s done: %0d errors", name, errors);
        end
    endtask

    always @(negedge clk) begin : result_monitor
        int due;
        if (cycle > RESET_CYCLES) begin
            due = -1;
            for (int r = 1; r < 32; r++) begin
                if (exp_cyc[r].size() != 0 && exp_cyc[r][0] == cycle) begin
                    due = r;
                end
            end
            if (due >= 0) begin
                expect_flag("wb_valid", wb_valid, 1'b1);
                compare_addr("wb_rd", wb_rd, reg_addr_t'(due));
                check_word("wb_data", wb_data, exp_val[due][0]);
                void'(exp_val[due].pop_front());
                void'(exp_cyc[due].pop_front());
                outstanding--;
            end else if (wb_valid) begin
                error_count++;
                $display("Unexpected write-back to x%0d at %0t", wb_rd, $time);
            end
            if (ill_cyc.size() != 0 && ill_cyc[0] == cycle) begin
                expect_flag("illegal", illegal, 1'b1);
                void'(ill_cyc.pop_front());
                outstanding--;
            end else begin
                expect_flag("illegal", illegal, 1'b0);
            end
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin : main_sequence
        int first_err;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        // Legal op with rs1 and rd, so instr_ready reflects the scoreboard
        instr       = i_type(12'h001, 1, 3'd0, 1);
        model_regs[0] = '0;
        build_table();
        timeout_limit = tbl_instr.size() * 8 + 50;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        first_err = error_count;
        expect_flag("wb_valid", wb_valid, 1'b0);
        expect_flag("illegal", illegal, 1'b0);
        expect_flag("instr_ready", instr_ready, 1'b1);
        report_test("reset", error_count - first_err);

        for (int g = 0; g < GROUP_COUNT; g++) begin
            first_err = error_count;
            for (int i = 0; i < tbl_instr.size(); i++) begin
                if (tbl_group[i] == g) begin
                    drive_one(i);
                end
            end
            @(negedge clk);
            instr_valid = 1'b0;
            // Let every expected result and illegal pulse come out
            while (outstanding != 0) begin
                @(negedge clk);
                #1;
            end
            report_test(group_name[g], error_count - first_err);
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 tests_run, tests_passed, tests_run - tests_passed, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/core_defines.svh
/* Core-wide sizes. The multiplier datapath is built for a latency of three
   stages, and the register count must be a power of two */

`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Integer data path width
`define CORE_XLEN 32

// Architectural integer registers, x0 included
`define CORE_REG_COUNT 32

// Edges from issue to the registered multiplier result
`define CORE_MUL_LATENCY 3

`endif

//--- verilog/core_pkg.sv
/* Shared types of the integer core. LUI has no ALU code of its own and
   travels as ALU_ADD with a zero first operand */

`default_nettype none

`include "core_defines.svh"

package core_pkg;

    //////////////////////////////////////////////////
    // Data widths with a meaning
    //////////////////////////////////////////////////

    // Operand or result
    typedef logic [`CORE_XLEN-1:0] word_t;

    // Raw instruction as fetched
    typedef logic [31:0] instr_t;

    // Register index
    typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_addr_t;

    //////////////////////////////////////////////////
    // Execution selectors
    //////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // Target unit of an issued operation
    typedef enum logic {
        UNIT_ALU,
        UNIT_MUL
    } unit_t;

endpackage

`default_nettype wire

//--- verilog/decode_issue.sv
/* RV32I OP, OP-IMM and LUI plus MUL. One pending write per register, and
   write-back slots are reserved at issue by fixed unit latency */

`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module decode_issue
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_valid,
    input  instr_t    instr,
    output logic      instr_ready,
    output logic      illegal,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    input  logic      wb_valid,
    input  reg_addr_t wb_rd,
    issue_if.source   issue
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd_f;
    reg_addr_t  rs1_f;
    reg_addr_t  rs2_f;
    word_t      imm_i;

    logic    legal;
    logic    is_mul;
    logic    uses_rs1;
    logic    uses_rs2;
    logic    alt_ok;
    alu_op_t alu_op;
    word_t   imm;

    logic [`CORE_REG_COUNT-1:0]    pending;
    logic [`CORE_MUL_LATENCY-2:0]  mul_hist;
    logic hazard;
    logic accept;
    logic illegal_d;

    function automatic alu_op_t base_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  base_op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  base_op = ALU_SLL;
            3'b010:  base_op = ALU_SLT;
            3'b011:  base_op = ALU_SLTU;
            3'b100:  base_op = ALU_XOR;
            3'b101:  base_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  base_op = ALU_OR;
            default: base_op = ALU_AND;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Field extraction and decode
    //////////////////////////////////////////////////

    assign opcode = instr[6:0];
    assign rd_f   = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1_f  = instr[19:15];
    assign rs2_f  = instr[24:20];
    assign funct7 = instr[31:25];
    assign imm_i  = word_t'($signed(instr[31:20]));

    // Only sub and sra use the alternate funct7
    assign alt_ok = (funct7 == F7_ALT) && ((funct3 == 3'b000) || (funct3 == 3'b101));

    always_comb begin
        legal    = 1'b0;
        is_mul   = 1'b0;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        alu_op   = ALU_ADD;
        imm      = imm_i;
        case (opcode)
            OPC_OP: begin
                uses_rs2 = 1'b1;
                if (funct7 == F7_MULDIV) begin
                    legal  = (funct3 == 3'b000);
                    is_mul = 1'b1;
                end else begin
                    legal  = (funct7 == F7_BASE) || alt_ok;
                    alu_op = base_op(funct3, funct7 == F7_ALT);
                end
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b001) begin
                    legal = (funct7 == F7_BASE);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                end else begin
                    legal = 1'b1;
                end
                alu_op = base_op(funct3, (funct3 == 3'b101) && (funct7 == F7_ALT));
            end
            OPC_LUI: begin
                legal    = 1'b1;
                uses_rs1 = 1'b0;
                imm      = {instr[31:12], 12'b0};
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // LUI reads x0 so operand_a comes out as zero
    assign rs1_addr = uses_rs1 ? rs1_f : '0;
    assign rs2_addr = uses_rs2 ? rs2_f : '0;

    //////////////////////////////////////////////////
    // Hazards and handshake
    //////////////////////////////////////////////////

    // pending[0] is never set, so x0 needs no special case
    // An ALU op now would collide with the MUL issued LAT-1 cycles ago
    assign hazard = (uses_rs1 && pending[rs1_f])
                 || (uses_rs2 && pending[rs2_f])
                 || pending[rd_f]
                 || (!is_mul && mul_hist[`CORE_MUL_LATENCY-2]);

    // Illegal encodings are taken at once
    assign instr_ready = !(legal && hazard);
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending  <= '0;
            mul_hist <= '0;
        end else begin
            if (wb_valid) begin
                pending[wb_rd] <= 1'b0;
            end
            if (accept && legal && (rd_f != '0)) begin
                pending[rd_f] <= 1'b1;
            end
            mul_hist <= {mul_hist[`CORE_MUL_LATENCY-3:0], accept && legal && is_mul};
        end
    end

    //////////////////////////////////////////////////
    // Issue packet
    //////////////////////////////////////////////////

    // Illegal flag comes out one edge after acceptance, like a unit result
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue.valid <= 1'b0;
            illegal_d   <= 1'b0;
            illegal     <= 1'b0;
        end else begin
            issue.valid <= accept && legal;
            illegal_d   <= accept && !legal;
            illegal     <= illegal_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue.unit      <= is_mul ? UNIT_MUL : UNIT_ALU;
            issue.alu_op    <= alu_op;
            issue.rd        <= rd_f;
            issue.operand_a <= rs1_data;
            issue.operand_b <= uses_rs2 ? rs2_data : imm;
        end
    end

    // A write in flight keeps its register marked pending
    a_rd_pending : assert property (
        @(posedge clk) disable iff (!rst_n)
        (issue.valid && (issue.rd != '0)) |-> pending[issue.rd]
    ) else $error("issued write not marked pending in the scoreboard");

endmodule

`default_nettype wire

//--- verilog/execute_units.sv
/* Registered ALU and a three-stage multiplier giving the low product word.
   Issue must already keep the two result valids apart */

`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module execute_units
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    issue_if.sink    issue,
    result_if.source result
);

    localparam int HALF    = `CORE_XLEN / 2;
    localparam int LAT     = `CORE_MUL_LATENCY;
    localparam int SHAMT_W = $clog2(`CORE_XLEN);

    logic [SHAMT_W-1:0] shamt;
    word_t              alu_next;
    logic               alu_issue;
    logic               mul_issue;

    // Multiplier tags and partial products
    logic [LAT-1:0]  mul_vld;
    reg_addr_t       mul_tag [LAT];
    word_t           m1_ll;
    logic [HALF-1:0] m1_hl;
    logic [HALF-1:0] m1_lh;
    word_t           m2_ll;
    logic [HALF-1:0] m2_cross;

    // Data stages below are written out for exactly three edges
    if (LAT != 3) begin : g_lat_check
        $error("multiplier datapath expects a latency of three");
    end

    assign alu_issue = issue.valid && (issue.unit == UNIT_ALU);
    assign mul_issue = issue.valid && (issue.unit == UNIT_MUL);
    assign shamt     = issue.operand_b[SHAMT_W-1:0];

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////

    always_comb begin
        case (issue.alu_op)
            ALU_SUB:  alu_next = issue.operand_a - issue.operand_b;
            ALU_SLL:  alu_next = issue.operand_a << shamt;
            ALU_SLT:  alu_next = word_t'($signed(issue.operand_a) < $signed(issue.operand_b));
            ALU_SLTU: alu_next = word_t'(issue.operand_a < issue.operand_b);
            ALU_XOR:  alu_next = issue.operand_a ^ issue.operand_b;
            ALU_SRL:  alu_next = issue.operand_a >> shamt;
            ALU_SRA:  alu_next = word_t'($signed(issue.operand_a) >>> shamt);
            ALU_OR:   alu_next = issue.operand_a | issue.operand_b;
            ALU_AND:  alu_next = issue.operand_a & issue.operand_b;
            default:  alu_next = issue.operand_a + issue.operand_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result.alu_valid <= 1'b0;
        end else begin
            result.alu_valid <= alu_issue;
        end
    end

    always_ff @(posedge clk) begin
        result.alu_rd   <= issue.rd;
        result.alu_data <= alu_next;
    end

    //////////////////////////////////////////////////
    // Multiplier
    //////////////////////////////////////////////////

    // Low word only, so the high-by-high term drops out
    // and cross terms need only their low halves
    always_ff @(posedge clk) begin
        m1_ll    <= issue.operand_a[HALF-1:0] * issue.operand_b[HALF-1:0];
        m1_hl    <= issue.operand_a[`CORE_XLEN-1:HALF] * issue.operand_b[HALF-1:0];
        m1_lh    <= issue.operand_a[HALF-1:0] * issue.operand_b[`CORE_XLEN-1:HALF];
        m2_ll    <= m1_ll;
        m2_cross <= m1_hl + m1_lh;
        result.mul_data <= m2_ll + {m2_cross, {HALF{1'b0}}};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mul_vld <= '0;
        end else begin
            mul_vld <= {mul_vld[LAT-2:0], mul_issue};
        end
    end

    always_ff @(posedge clk) begin
        mul_tag[0] <= issue.rd;
        for (int i = 1; i < LAT; i++) begin
            mul_tag[i] <= mul_tag[i-1];
        end
    end

    assign result.mul_valid = mul_vld[LAT-1];
    assign result.mul_rd    = mul_tag[LAT-1];

endmodule

`default_nettype wire

//--- verilog/int_core_top.sv
/* Integer execution core with a valid/ready instruction port. instr_ready
   depends on the presented instr, which must be held until accepted */

`timescale 1ns/1ps
`default_nettype none

module int_core_top
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_valid,
    input  instr_t    instr,
    output logic      instr_ready,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data,
    output logic      illegal
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    issue_if  issue_bus ();
    result_if result_bus ();

    //////////////////////////////////////////////////
    // Register file and decode
    //////////////////////////////////////////////////

    register_file u_regfile (
        .clk      (clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    // Scoreboard clears on the register file write edge
    decode_issue u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .illegal     (illegal),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .wb_valid    (wr_en),
        .wb_rd       (wr_addr),
        .issue       (issue_bus)
    );

    //////////////////////////////////////////////////
    // Units and write-back
    //////////////////////////////////////////////////

    execute_units u_exec (
        .clk    (clk),
        .rst_n  (rst_n),
        .issue  (issue_bus),
        .result (result_bus)
    );

    writeback u_wb (
        .clk      (clk),
        .rst_n    (rst_n),
        .result   (result_bus),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

`default_nettype wire

//--- verilog/issue_if.sv
/* One issued operation from decode to execute. No ready: the write-back
   slot is already reserved when valid rises */

`timescale 1ns/1ps
`default_nettype none

interface issue_if
    import core_pkg::*;
    ();

    // High for a single cycle per legal accepted instruction
    logic      valid;
    unit_t     unit;
    alu_op_t   alu_op;
    reg_addr_t rd;

    // operand_b holds rs2 or the immediate
    word_t     operand_a;
    word_t     operand_b;

    modport source (
        output valid,
        output unit,
        output alu_op,
        output rd,
        output operand_a,
        output operand_b
    );

    modport sink (
        input valid,
        input unit,
        input alu_op,
        input rd,
        input operand_a,
        input operand_b
    );

endinterface

`default_nettype wire

//--- verilog/register_file.sv
/* Asynchronous reads, one synchronous write. x0 reads as zero and
   entries hold no reset value */

`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module register_file
    import core_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output word_t     rs1_data,
    output word_t     rs2_data,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [`CORE_REG_COUNT];

    always_ff @(posedge clk) begin
        if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 entry is never written, mask it on read
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Write-back filters x0 before it gets here
    a_no_x0_write : assert property (
        @(posedge clk) wr_en |-> (wr_addr != '0)
    ) else $error("register file write to x0");

endmodule

`default_nettype wire

//--- verilog/result_if.sv
/* Finished unit results toward write-back. At most one of the two valids
   is high in any cycle */

`timescale 1ns/1ps
`default_nettype none

interface result_if
    import core_pkg::*;
    ();

    // Single-cycle ALU
    logic      alu_valid;
    reg_addr_t alu_rd;
    word_t     alu_data;

    // Pipelined multiplier
    logic      mul_valid;
    reg_addr_t mul_rd;
    word_t     mul_data;

    modport source (
        output alu_valid, alu_rd, alu_data,
        output mul_valid, mul_rd, mul_data
    );

    modport sink (
        input alu_valid, alu_rd, alu_data,
        input mul_valid, mul_rd, mul_data
    );

endinterface

`default_nettype wire

//--- verilog/writeback.sv
/* Single write port shared by ALU and MUL. Results to x0 are dropped here
   and never reach the register file or the outputs */

`timescale 1ns/1ps
`default_nettype none

module writeback
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    result_if.sink    result,
    output logic      wr_en,
    output reg_addr_t wr_addr,
    output word_t     wr_data,
    output logic      wb_valid,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    logic      sel_valid;
    reg_addr_t sel_rd;
    word_t     sel_data;

    // Issue reserved the slot, so no arbitration
    assign sel_valid = result.alu_valid || result.mul_valid;
    assign sel_rd    = result.mul_valid ? result.mul_rd : result.alu_rd;
    assign sel_data  = result.mul_valid ? result.mul_data : result.alu_data;

    assign wr_en   = sel_valid && (sel_rd != '0);
    assign wr_addr = sel_rd;
    assign wr_data = sel_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= wr_en;
        end
    end

    // Outputs hold the last written result
    always_ff @(posedge clk) begin
        if (wr_en) begin
            wb_rd   <= sel_rd;
            wb_data <= sel_data;
        end
    end

    a_one_unit : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(result.alu_valid && result.mul_valid)
    ) else $error("ALU and MUL finished in the same cycle");

endmodule

`default_nettype wire
